// File: logic/display_cfg_pkg.sv
`default_nettype none

package display_cfg_pkg;

    // Screen geometry in pixels.
    localparam int DEFAULT_RES_X = 400;
    localparam int DEFAULT_RES_Y = 300;

    // Palette size and color depth.
    localparam int DEFAULT_PALETTE_LENGTH = 256;
    localparam int DEFAULT_COLOR_BITS = 12;

    // Status word layout, reset value is 32'h10.
    localparam int STATUS_IDLE_BIT = 4;
    localparam int STATUS_OVERRUN_BIT = 5;

endpackage

`default_nettype wire

// File: logic/display_cmd_pkg.sv
`default_nettype none

package display_cmd_pkg;

    // Opcode in command bits 31 to 28.
    typedef enum logic [3:0] {
        OP_NOP        = 4'h0,
        OP_SET_POS    = 4'h1,
        OP_SET_INDEX  = 4'h2,
        OP_PLOT       = 4'h3,
        OP_FILL       = 4'h4,
        OP_PALETTE    = 4'h5,
        OP_SOFT_RESET = 4'h6
    } cmd_op_e;

    // Drawing view. Argument holds position, index or run length.
    typedef struct packed {
        cmd_op_e     op;
        logic [3:0]  spare;
        logic [23:0] arg;
    } draw_view_t;

    // Palette view.
    typedef struct packed {
        cmd_op_e     op;
        logic [7:0]  entry;
        logic [7:0]  spare;
        logic [11:0] color;
    } pal_view_t;

    typedef union packed {
        draw_view_t draw;
        pal_view_t  pal;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: logic/draw_control.sv
`default_nettype none

module draw_control (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  display_cmd_pkg::cmd_word_u cmd_i,
    input  logic                      cmd_valid_i,
    input  logic                      last_pixel_i,

    output logic                      load_pos_o,
    output logic                      load_index_o,
    output logic                      load_count_o,
    output logic                      pal_write_o,
    output logic                      pix_write_o,
    output logic                      soft_rst_o,

    output logic [31:0]               status_o
);
    import display_cfg_pkg::*;
    import display_cmd_pkg::*;

    typedef enum logic {
        IDLE,
        FILLING
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        busy_q;
    logic        overrun_q;
    logic        idle;
    logic        accept;
    logic        fill_start;
    logic [15:0] fill_len;

    // Busy covers every cycle in which a fill pixel leaves the datapath.
    assign idle = !busy_q;
    assign accept = cmd_valid_i && idle;
    assign fill_len = cmd_i.draw.arg[15:0];

    always_comb begin
        state_d = state_q;
        load_pos_o = 1'b0;
        load_index_o = 1'b0;
        load_count_o = 1'b0;
        pal_write_o = 1'b0;
        pix_write_o = 1'b0;
        soft_rst_o = 1'b0;
        fill_start = 1'b0;

        case (state_q)
            IDLE: begin
                if (accept) begin
                    case (cmd_i.draw.op)
                        OP_SET_POS: load_pos_o = 1'b1;
                        OP_SET_INDEX: load_index_o = 1'b1;
                        OP_PLOT: pix_write_o = 1'b1;
                        OP_FILL: begin
                            // First pixel goes out with the load.
                            if (fill_len != 16'd0) begin
                                load_count_o = 1'b1;
                                pix_write_o = 1'b1;
                                fill_start = 1'b1;
                                if (fill_len != 16'd1) begin
                                    state_d = FILLING;
                                end
                            end
                        end
                        OP_PALETTE: pal_write_o = 1'b1;
                        OP_SOFT_RESET: soft_rst_o = 1'b1;
                        default: ;
                    endcase
                end
            end
            FILLING: begin
                pix_write_o = 1'b1;
                if (last_pixel_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || soft_rst_o) begin
            state_q <= IDLE;
            busy_q <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q <= fill_start || (state_q == FILLING);
            // Sticky until reset.
            if (cmd_valid_i && !idle) begin
                overrun_q <= 1'b1;
            end
        end
    end

    always_comb begin
        status_o = '0;
        status_o[STATUS_IDLE_BIT] = idle;
        status_o[STATUS_OVERRUN_BIT] = overrun_q;
    end

endmodule

`default_nettype wire

// File: logic/draw_datapath.sv
`default_nettype none

module draw_datapath #(
    parameter int RES_X = 400,
    parameter int RES_Y = 300,
    parameter int PALETTE_LENGTH = 256,
    parameter int COLOR_BITS = 12
) (
    input  logic                              clk_i,
    input  logic                              rst_i,

    input  display_cmd_pkg::cmd_word_u        cmd_i,

    input  logic                              load_pos_i,
    input  logic                              load_index_i,
    input  logic                              load_count_i,
    input  logic                              pal_write_i,
    input  logic                              pix_write_i,
    input  logic                              soft_rst_i,

    output logic                              last_pixel_o,

    output logic [$clog2(RES_X)-1:0]          fb_wr_x_o,
    output logic [$clog2(RES_Y)-1:0]          fb_wr_y_o,
    output logic [$clog2(PALETTE_LENGTH)-1:0] fb_wr_index_o,
    output logic                              fb_wr_en_o,

    output logic [$clog2(PALETTE_LENGTH)-1:0] pal_wr_index_o,
    output logic [COLOR_BITS-1:0]             pal_wr_color_o,
    output logic                              pal_wr_en_o
);
    localparam int X_W = $clog2(RES_X);
    localparam int Y_W = $clog2(RES_Y);
    localparam int IDX_W = $clog2(PALETTE_LENGTH);
    localparam logic [X_W-1:0] X_MAX = X_W'(RES_X - 1);
    localparam logic [Y_W-1:0] Y_MAX = Y_W'(RES_Y - 1);

    logic [X_W-1:0]   x_q;
    logic [Y_W-1:0]   y_q;
    logic [IDX_W-1:0] index_q;
    logic [15:0]      count_q;
    logic [X_W-1:0]   pos_x;
    logic [Y_W-1:0]   pos_y;
    logic             clear;

    assign clear = rst_i || soft_rst_i;
    assign last_pixel_o = (count_q == 16'd1);

    // Clamp the loaded position to the screen.
    always_comb begin
        if (int'(cmd_i.draw.arg[11:0]) >= RES_X) begin
            pos_x = X_MAX;
        end else begin
            pos_x = X_W'(cmd_i.draw.arg[11:0]);
        end
        if (int'(cmd_i.draw.arg[23:12]) >= RES_Y) begin
            pos_y = Y_MAX;
        end else begin
            pos_y = Y_W'(cmd_i.draw.arg[23:12]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear) begin
            x_q <= '0;
            y_q <= '0;
            index_q <= '0;
            count_q <= '0;
        end else begin
            if (load_pos_i) begin
                x_q <= pos_x;
                y_q <= pos_y;
            end else if (pix_write_i) begin
                // Row wrap, then screen wrap.
                if (x_q == X_MAX) begin
                    x_q <= '0;
                    if (y_q == Y_MAX) begin
                        y_q <= '0;
                    end else begin
                        y_q <= y_q + 1'b1;
                    end
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end

            if (load_index_i) begin
                index_q <= IDX_W'(cmd_i.draw.arg);
            end

            // Count is what remains after the pixel sent with the load.
            if (load_count_i) begin
                count_q <= cmd_i.draw.arg[15:0] - 16'd1;
            end else if (pix_write_i && count_q != 16'd0) begin
                count_q <= count_q - 16'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear) begin
            fb_wr_en_o <= 1'b0;
            pal_wr_en_o <= 1'b0;
        end else begin
            fb_wr_en_o <= pix_write_i;
            pal_wr_en_o <= pal_write_i;
        end
    end

    // Write payload, qualified by the enables.
    always_ff @(posedge clk_i) begin
        if (pix_write_i) begin
            fb_wr_x_o <= x_q;
            fb_wr_y_o <= y_q;
            fb_wr_index_o <= index_q;
        end
        if (pal_write_i) begin
            pal_wr_index_o <= IDX_W'(cmd_i.pal.entry);
            pal_wr_color_o <= COLOR_BITS'(cmd_i.pal.color);
        end
    end

endmodule

`default_nettype wire

// File: logic/display_processor.sv
`default_nettype none

module display_processor #(
    parameter int RES_X = display_cfg_pkg::DEFAULT_RES_X,
    parameter int RES_Y = display_cfg_pkg::DEFAULT_RES_Y,
    parameter int PALETTE_LENGTH = display_cfg_pkg::DEFAULT_PALETTE_LENGTH,
    parameter int COLOR_BITS = display_cfg_pkg::DEFAULT_COLOR_BITS
) (
    input  logic                              clk_i,
    input  logic                              rst_i,

    input  logic [31:0]                       cmd_i,
    input  logic                              cmd_valid_i,

    output logic [31:0]                       status_o,

    output logic [$clog2(RES_X)-1:0]          fb_wr_x_o,
    output logic [$clog2(RES_Y)-1:0]          fb_wr_y_o,
    output logic [$clog2(PALETTE_LENGTH)-1:0] fb_wr_index_o,
    output logic                              fb_wr_en_o,

    output logic [$clog2(PALETTE_LENGTH)-1:0] pal_wr_index_o,
    output logic [COLOR_BITS-1:0]             pal_wr_color_o,
    output logic                              pal_wr_en_o
);
    logic load_pos;
    logic load_index;
    logic load_count;
    logic pal_write;
    logic pix_write;
    logic soft_rst;
    logic last_pixel;

    draw_control u_control (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .last_pixel_i (last_pixel),
        .load_pos_o   (load_pos),
        .load_index_o (load_index),
        .load_count_o (load_count),
        .pal_write_o  (pal_write),
        .pix_write_o  (pix_write),
        .soft_rst_o   (soft_rst),
        .status_o     (status_o)
    );

    draw_datapath #(
        .RES_X          (RES_X),
        .RES_Y          (RES_Y),
        .PALETTE_LENGTH (PALETTE_LENGTH),
        .COLOR_BITS     (COLOR_BITS)
    ) u_datapath (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_i          (cmd_i),
        .load_pos_i     (load_pos),
        .load_index_i   (load_index),
        .load_count_i   (load_count),
        .pal_write_i    (pal_write),
        .pix_write_i    (pix_write),
        .soft_rst_i     (soft_rst),
        .last_pixel_o   (last_pixel),
        .fb_wr_x_o      (fb_wr_x_o),
        .fb_wr_y_o      (fb_wr_y_o),
        .fb_wr_index_o  (fb_wr_index_o),
        .fb_wr_en_o     (fb_wr_en_o),
        .pal_wr_index_o (pal_wr_index_o),
        .pal_wr_color_o (pal_wr_color_o),
        .pal_wr_en_o    (pal_wr_en_o)
    );

endmodule

`default_nettype wire

// File: testbench/display_checker.sv
`default_nettype none

module display_checker #(
    parameter int X_W = 9,
    parameter int Y_W = 9,
    parameter int IDX_W = 8,
    parameter int C_W = 12
) (
    input  logic                       clk_i,
    input  logic                       check_en_i,
    input  int                         cycle_i,
    input  display_cmd_pkg::cmd_word_u cmd_i,
    input  logic                       cmd_valid_i,
    input  logic [31:0]                status_i,
    input  logic [31:0]                exp_status_i,
    input  logic [X_W-1:0]             fb_x_i,
    input  logic [Y_W-1:0]             fb_y_i,
    input  logic [IDX_W-1:0]           fb_index_i,
    input  logic                       fb_en_i,
    input  logic [IDX_W-1:0]           pal_index_i,
    input  logic [C_W-1:0]             pal_color_i,
    input  logic                       pal_en_i
);
    import display_cfg_pkg::*;
    import display_cmd_pkg::*;

    int errors = 0;
    int pix_seen = 0;
    int pal_seen = 0;
    int drops = 0;
    cmd_op_e last_drop_op;
    int exp_pix_cyc[$];
    int exp_x[$];
    int exp_y[$];
    int exp_idx[$];
    int exp_pal_cyc[$];
    int exp_pal_idx[$];
    int exp_pal_color[$];

    function automatic void expect_pixel(int cyc, int x, int y, int idx);
        exp_pix_cyc.push_back(cyc);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_idx.push_back(idx);
    endfunction

    function automatic void expect_palette(int cyc, int idx, int color);
        exp_pal_cyc.push_back(cyc);
        exp_pal_idx.push_back(idx);
        exp_pal_color.push_back(color);
    endfunction

    function automatic void compare(string name, int exp, int got);
        if (exp != got) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endfunction

    always @(posedge clk_i) begin
        if (check_en_i) begin
            if (status_i !== exp_status_i) begin
                $display("ERROR status_o expected %h got %h", exp_status_i, status_i);
                errors++;
            end
            if (cmd_valid_i && !status_i[STATUS_IDLE_BIT]) begin
                drops++;
                last_drop_op = cmd_i.draw.op;
            end

            if (fb_en_i !== 1'b0) begin
                pix_seen++;
                if (exp_pix_cyc.size() == 0) begin
                    $display("Unexpected framebuffer write in cycle %0d", cycle_i);
                    errors++;
                end else begin
                    compare("fb_wr_en_o cycle", exp_pix_cyc.pop_front(), cycle_i);
                    compare("fb_wr_x_o", exp_x.pop_front(), int'(fb_x_i));
                    compare("fb_wr_y_o", exp_y.pop_front(), int'(fb_y_i));
                    compare("fb_wr_index_o", exp_idx.pop_front(), int'(fb_index_i));
                end
            end else if (exp_pix_cyc.size() != 0 && exp_pix_cyc[0] <= cycle_i) begin
                $display("Framebuffer write expected in cycle %0d never came", exp_pix_cyc[0]);
                errors++;
                void'(exp_pix_cyc.pop_front());
                void'(exp_x.pop_front());
                void'(exp_y.pop_front());
                void'(exp_idx.pop_front());
            end

            if (pal_en_i !== 1'b0) begin
                pal_seen++;
                if (exp_pal_cyc.size() == 0) begin
                    $display("Unexpected palette write in cycle %0d", cycle_i);
                    errors++;
                end else begin
                    compare("pal_wr_en_o cycle", exp_pal_cyc.pop_front(), cycle_i);
                    compare("pal_wr_index_o", exp_pal_idx.pop_front(), int'(pal_index_i));
                    compare("pal_wr_color_o", exp_pal_color.pop_front(), int'(pal_color_i));
                end
            end else if (exp_pal_cyc.size() != 0 && exp_pal_cyc[0] <= cycle_i) begin
                $display("Palette write expected in cycle %0d never came", exp_pal_cyc[0]);
                errors++;
                void'(exp_pal_cyc.pop_front());
                void'(exp_pal_idx.pop_front());
                void'(exp_pal_color.pop_front());
            end
        end
    end

    task automatic check_leftovers();
        if (exp_pix_cyc.size() != 0 || exp_pal_cyc.size() != 0) begin
            $display("%0d framebuffer and %0d palette writes were still outstanding",
                     exp_pix_cyc.size(), exp_pal_cyc.size());
            errors++;
        end
    endtask

endmodule

`default_nettype wire

// File: testbench/display_processor_tb.sv
`default_nettype none

module display_processor_tb;
    import display_cfg_pkg::*;
    import display_cmd_pkg::*;

    localparam int PERIOD = 100;
    localparam int X_W = $clog2(DEFAULT_RES_X);
    localparam int Y_W = $clog2(DEFAULT_RES_Y);
    localparam int IDX_W = $clog2(DEFAULT_PALETTE_LENGTH);
    localparam int C_W = DEFAULT_COLOR_BITS;
    // Command cycles plus the longest possible fills.
    localparam int TOTAL_CYCLES = 150 + 4 * 1024 + 420 + 30;

    logic             clk_i = 1'b0;
    logic             rst_i;
    cmd_word_u        cmd_i;
    logic             cmd_valid_i;
    logic [31:0]      status_o;
    logic [31:0]      exp_status;
    logic [X_W-1:0]   fb_wr_x_o;
    logic [Y_W-1:0]   fb_wr_y_o;
    logic [IDX_W-1:0] fb_wr_index_o;
    logic             fb_wr_en_o;
    logic [IDX_W-1:0] pal_wr_index_o;
    logic [C_W-1:0]   pal_wr_color_o;
    logic             pal_wr_en_o;
    logic             check_en = 1'b0;
    int               cycle = 0;
    int               seed = 43430;
    int               tests = 0;
    int               tb_errors = 0;
    int               drops_before;
    logic [31:0]      rnd_word;

    // Reference model state.
    int   mx;
    int   my;
    int   midx;
    int   busy_left;
    logic overrun;

    always #(PERIOD / 2) clk_i = ~clk_i;

    display_processor DUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_i          (cmd_i),
        .cmd_valid_i    (cmd_valid_i),
        .status_o       (status_o),
        .fb_wr_x_o      (fb_wr_x_o),
        .fb_wr_y_o      (fb_wr_y_o),
        .fb_wr_index_o  (fb_wr_index_o),
        .fb_wr_en_o     (fb_wr_en_o),
        .pal_wr_index_o (pal_wr_index_o),
        .pal_wr_color_o (pal_wr_color_o),
        .pal_wr_en_o    (pal_wr_en_o)
    );

    display_checker #(.X_W(X_W), .Y_W(Y_W), .IDX_W(IDX_W), .C_W(C_W)) u_checker (
        .clk_i (clk_i), .check_en_i (check_en), .cycle_i (cycle),
        .cmd_i (cmd_i), .cmd_valid_i (cmd_valid_i),
        .status_i (status_o), .exp_status_i (exp_status),
        .fb_x_i (fb_wr_x_o), .fb_y_i (fb_wr_y_o), .fb_index_i (fb_wr_index_o),
        .fb_en_i (fb_wr_en_o), .pal_index_i (pal_wr_index_o),
        .pal_color_i (pal_wr_color_o), .pal_en_i (pal_wr_en_o)
    );

    function automatic void advance_cursor();
        if (mx == DEFAULT_RES_X - 1) begin
            mx = 0;
            my = (my == DEFAULT_RES_Y - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
    endfunction

    // Status during this cycle, then the effect of the command at its closing edge.
    function automatic void model_command(cmd_word_u c, logic valid);
        int   n;
        logic was_busy;
        was_busy = (busy_left != 0);
        exp_status = '0;
        exp_status[STATUS_IDLE_BIT] = !was_busy;
        exp_status[STATUS_OVERRUN_BIT] = overrun;
        if (valid && was_busy) begin
            overrun = 1'b1;
        end else if (valid) begin
            case (c.draw.op)
                OP_SET_POS: begin
                    mx = (c.draw.arg[11:0] >= DEFAULT_RES_X) ? DEFAULT_RES_X - 1
                                                              : c.draw.arg[11:0];
                    my = (c.draw.arg[23:12] >= DEFAULT_RES_Y) ? DEFAULT_RES_Y - 1
                                                               : c.draw.arg[23:12];
                end
                OP_SET_INDEX: midx = c.draw.arg[IDX_W-1:0];
                OP_PLOT: begin
                    u_checker.expect_pixel(cycle + 1, mx, my, midx);
                    advance_cursor();
                end
                OP_FILL: begin
                    n = c.draw.arg[15:0];
                    for (int k = 0; k < n; k++) begin
                        u_checker.expect_pixel(cycle + 1 + k, mx, my, midx);
                        advance_cursor();
                    end
                    busy_left = n;
                end
                OP_PALETTE: u_checker.expect_palette(cycle + 1, c.pal.entry, c.pal.color);
                OP_SOFT_RESET: begin
                    mx = 0;
                    my = 0;
                    midx = 0;
                    overrun = 1'b0;
                end
                default: ;
            endcase
        end
        if (was_busy) begin
            busy_left = busy_left - 1;
        end
    endfunction

    function automatic cmd_word_u draw_cmd(cmd_op_e op, logic [23:0] arg);
        cmd_word_u c;
        c.draw.op = op;
        c.draw.spare = 4'h0;
        c.draw.arg = arg;
        return c;
    endfunction

    task automatic issue(cmd_word_u c, logic valid);
        @(negedge clk_i);
        cycle++;
        cmd_i = c;
        cmd_valid_i = valid;
        model_command(c, valid);
    endtask

    task automatic wait_idle();
        issue(32'h0, 1'b0);
        while (!status_o[STATUS_IDLE_BIT]) begin
            issue(32'h0, 1'b0);
        end
        issue(32'h0, 1'b0);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("Test %0d %s done, %0d errors so far", tests, name,
                 u_checker.errors + tb_errors);
    endtask

    initial begin
        #(20 * TOTAL_CYCLES * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_i = 1'b1;
        cmd_i = '0;
        cmd_valid_i = 1'b0;
        exp_status = 32'h10;
        mx = 0;
        my = 0;
        midx = 0;
        busy_left = 0;
        overrun = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        check_en = 1'b1;

        repeat (4) issue(32'h0, 1'b0);
        end_test("reset");

        issue(draw_cmd(OP_SET_POS, {12'd45, 12'd123}), 1'b1);
        issue(draw_cmd(OP_SET_INDEX, 24'hA5), 1'b1);
        issue(draw_cmd(OP_PLOT, 24'h0), 1'b1);
        wait_idle();
        issue(draw_cmd(OP_SET_POS, {12'd4000, 12'd3000}), 1'b1);
        issue(draw_cmd(OP_PLOT, 24'h0), 1'b1);
        wait_idle();
        end_test("plot");

        for (int i = 0; i < 4; i++) begin
            issue(draw_cmd(OP_SET_POS, 24'($random(seed))), 1'b1);
            issue(draw_cmd(OP_SET_INDEX, 24'($random(seed))), 1'b1);
            issue(draw_cmd(OP_FILL, 24'(($random(seed) & 1023) + 1)), 1'b1);
            wait_idle();
        end
        // Runs through the last row and wraps to the top.
        issue(draw_cmd(OP_SET_POS, {12'd298, 12'd395}), 1'b1);
        issue(draw_cmd(OP_FILL, 24'd420), 1'b1);
        wait_idle();
        end_test("fill");

        drops_before = u_checker.drops;
        issue(draw_cmd(OP_FILL, 24'd30), 1'b1);
        issue(draw_cmd(OP_PLOT, 24'h0), 1'b1);
        issue(draw_cmd(OP_SET_INDEX, 24'h3C), 1'b1);
        wait_idle();
        if (u_checker.drops != drops_before + 2 || u_checker.last_drop_op != OP_SET_INDEX) begin
            $display("Commands sent during the fill were not dropped as expected");
            tb_errors++;
        end
        issue(draw_cmd(OP_FILL, 24'd0), 1'b1);
        wait_idle();
        end_test("overrun");

        for (int i = 0; i < 3; i++) begin
            rnd_word = 32'($random(seed));
            issue({OP_PALETTE, rnd_word[27:0]}, 1'b1);
        end
        wait_idle();
        end_test("palette");

        issue(draw_cmd(OP_SOFT_RESET, 24'h0), 1'b1);
        issue(draw_cmd(OP_PLOT, 24'h0), 1'b1);
        wait_idle();
        end_test("soft reset");

        u_checker.check_leftovers();
        $display("%0d tests, %0d pixel writes, %0d palette writes, %0d errors", tests,
                 u_checker.pix_seen, u_checker.pal_seen, u_checker.errors + tb_errors);
        if (u_checker.errors + tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/display_cfg_pkg.sv
logic/display_cmd_pkg.sv
logic/draw_control.sv
logic/draw_datapath.sv
logic/display_processor.sv
testbench/display_checker.sv
testbench/display_processor_tb.sv

// File: Bender.yml
package:
  name: display_processor

sources:
  - logic/display_cfg_pkg.sv
  - logic/display_cmd_pkg.sv
  - logic/draw_control.sv
  - logic/draw_datapath.sv
  - logic/display_processor.sv
  - target: test
    files:
      - testbench/display_checker.sv
      - testbench/display_processor_tb.sv
